//--- hdl/snd_reg_pkg.sv
package snd_reg_pkg;

    // register offsets, one word each
    localparam logic [7:0] ADDR_SND_CTRL = 8'h00;
    localparam logic [7:0] ADDR_SQ_CTRL  = 8'h04;
    localparam logic [7:0] ADDR_FIFO     = 8'h08;
    localparam logic [7:0] ADDR_STATUS   = 8'h0C;

    // status word bit positions
    localparam int STATUS_UNDERRUN_BIT = 8;
    localparam int STATUS_REQ_BIT      = 9;

    // master control, written through bits 7:0
    typedef struct packed {
        logic       master_en;
        logic       sq_left;
        logic       sq_right;
        logic       ds_left;
        logic       ds_right;
        logic       ds_full;
        logic [1:0] sq_shift;
    } snd_ctrl_t;

    // square channel control, written through bits 16:0
    typedef struct packed {
        logic [1:0]  duty;
        logic [3:0]  volume;
        logic [10:0] period;
    } sq_ctrl_t;

    // one FIFO entry, pushed as a word and played as bytes
    // byte 0 sits in bits 7:0 and plays first
    typedef union packed {
        logic [31:0]     raw;
        logic [3:0][7:0] bytes;
    } fifo_word_u;

endpackage : snd_reg_pkg

//--- hdl/snd_audio_pkg.sv
package snd_audio_pkg;

    // per channel sample
    typedef logic signed [7:0] chan_sample_t;

    // mixed output sample
    typedef logic signed [15:0] mix_sample_t;

    typedef struct packed {
        mix_sample_t left;
        mix_sample_t right;
    } stereo_t;

    // routing and scaling as seen by the mixer
    typedef struct packed {
        logic       sq_left;
        logic       sq_right;
        logic       ds_left;
        logic       ds_right;
        logic       ds_full;
        logic [1:0] sq_shift;
    } route_t;

endpackage : snd_audio_pkg

//--- hdl/snd_apb_regs.sv
`timescale 1ns/1ps

module snd_apb_regs #(
    parameter int FIFO_DEPTH = 8,
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1)
) (
    input  logic                   clk_100,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic [LVL_W-1:0]       level,
    input  logic                   full,
    input  logic                   underrun,
    input  logic                   fifo_req,
    output snd_reg_pkg::sq_ctrl_t  sq_cfg,
    output logic                   sq_restart,
    output logic                   push,
    output snd_reg_pkg::fifo_word_u push_word,
    output snd_audio_pkg::route_t  route,
    output logic                   chan_clear,
    output logic                   underrun_clear
);
    import snd_reg_pkg::*;

    snd_ctrl_t snd_ctrl;
    sq_ctrl_t  sq_ctrl;
    logic      access;
    logic      wr;
    logic      addr_ok;
    logic      err;

    // zero wait states
    assign pready = 1'b1;

    assign access = psel && penable;
    assign wr     = access && pwrite;

    always_comb begin
        addr_ok = paddr inside {ADDR_SND_CTRL, ADDR_SQ_CTRL, ADDR_FIFO, ADDR_STATUS};
        err     = 1'b0;
        if (!addr_ok) begin
            err = 1'b1;
        end else if (paddr == ADDR_FIFO) begin
            // FIFO is write only, and a full FIFO drops the word
            err = !pwrite || full;
        end
    end

    assign pslverr = access && err;

    // read mux
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                ADDR_SND_CTRL: prdata[7:0] = snd_ctrl;
                ADDR_SQ_CTRL:  prdata[16:0] = sq_ctrl;
                ADDR_STATUS: begin
                    prdata[7:0]                 = 8'(level);
                    prdata[STATUS_UNDERRUN_BIT] = underrun;
                    prdata[STATUS_REQ_BIT]      = fifo_req;
                end
                default: prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            snd_ctrl <= '0;
            sq_ctrl  <= '0;
        end else if (wr) begin
            if (paddr == ADDR_SND_CTRL) begin
                snd_ctrl <= snd_ctrl_t'(pwdata[7:0]);
            end
            if (paddr == ADDR_SQ_CTRL) begin
                sq_ctrl <= sq_ctrl_t'(pwdata[16:0]);
            end
        end
    end

    assign sq_cfg         = sq_ctrl;
    assign sq_restart     = wr && paddr == ADDR_SQ_CTRL;
    assign push           = wr && paddr == ADDR_FIFO && !full;
    assign push_word.raw  = pwdata;
    assign underrun_clear = wr && paddr == ADDR_STATUS && pwdata[STATUS_UNDERRUN_BIT];
    assign chan_clear     = !snd_ctrl.master_en;

    assign route = '{sq_left:  snd_ctrl.sq_left,
                     sq_right: snd_ctrl.sq_right,
                     ds_left:  snd_ctrl.ds_left,
                     ds_right: snd_ctrl.ds_right,
                     ds_full:  snd_ctrl.ds_full,
                     sq_shift: snd_ctrl.sq_shift};

endmodule : snd_apb_regs

//--- hdl/square_tone.sv
`timescale 1ns/1ps

module square_tone (
    input  logic                        clk_100,
    input  logic                        rst_n,
    input  logic                        sample_tick,
    input  snd_reg_pkg::sq_ctrl_t       sq_cfg,
    input  logic                        sq_restart,
    input  logic                        chan_clear,
    output snd_audio_pkg::chan_sample_t sq_sample
);
    import snd_audio_pkg::*;

    logic [10:0]  counter;
    logic [2:0]   step;
    logic [7:0]   duty_mask;
    logic         step_high;
    chan_sample_t amp;

    // period counter and duty step
    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            counter <= '0;
            step    <= '0;
        end else if (sq_restart || chan_clear) begin
            counter <= '0;
            step    <= '0;
        end else if (sample_tick) begin
            if (counter == sq_cfg.period) begin
                counter <= '0;
                step    <= step + 3'd1;
            end else begin
                counter <= counter + 11'd1;
            end
        end
    end

    // high steps per duty setting, bit n is step n
    always_comb begin
        case (sq_cfg.duty)
            2'd0:    duty_mask = 8'b1000_0000;
            2'd1:    duty_mask = 8'b1100_0000;
            2'd2:    duty_mask = 8'b1111_0000;
            default: duty_mask = 8'b1111_1100;
        endcase
    end

    assign step_high = duty_mask[step];

    // volume times 8
    assign amp = chan_sample_t'({1'b0, sq_cfg.volume, 3'b000});

    always_comb begin
        if (chan_clear) begin
            sq_sample = '0;
        end else if (step_high) begin
            sq_sample = amp;
        end else begin
            sq_sample = -amp;
        end
    end

endmodule : square_tone

//--- hdl/direct_sound_fifo.sv
`timescale 1ns/1ps

module direct_sound_fifo #(
    parameter int FIFO_DEPTH = 8,
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1)
) (
    input  logic                        clk_100,
    input  logic                        rst_n,
    input  logic                        sample_tick,
    input  logic                        push,
    input  snd_reg_pkg::fifo_word_u     push_word,
    input  logic                        chan_clear,
    input  logic                        underrun_clear,
    output snd_audio_pkg::chan_sample_t ds_sample,
    output logic [LVL_W-1:0]            level,
    output logic                        full,
    output logic                        underrun,
    output logic                        fifo_req
);
    import snd_reg_pkg::*;
    import snd_audio_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [LVL_W-1:0] DEPTH_L = LVL_W'(FIFO_DEPTH);
    localparam logic [LVL_W-1:0] HALF_L  = LVL_W'(FIFO_DEPTH / 2);

    fifo_word_u       mem [FIFO_DEPTH];
    fifo_word_u       head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [1:0]       byte_idx;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    // wraps for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign empty    = level == '0;
    assign full     = level == DEPTH_L;
    assign fifo_req = level <= HALF_L;
    assign head     = mem[rd_ptr];

    assign do_push = push && !full && !chan_clear;
    // word leaves once its last byte is played
    assign do_pop  = sample_tick && !empty && byte_idx == 2'd3 && !chan_clear;

    always_ff @(posedge clk_100) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // pointers, byte index and level; chan_clear flushes
    always_ff @(posedge clk_100) begin
        if (!rst_n || chan_clear) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            byte_idx <= '0;
            level    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (sample_tick && !empty) begin
                byte_idx <= byte_idx + 2'd1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // played sample and sticky underrun
    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            ds_sample <= '0;
            underrun  <= 1'b0;
        end else begin
            if (chan_clear) begin
                ds_sample <= '0;
            end else if (sample_tick) begin
                ds_sample <= empty ? '0 : chan_sample_t'(head.bytes[byte_idx]);
            end
            if (sample_tick && empty && !chan_clear) begin
                underrun <= 1'b1;
            end else if (underrun_clear) begin
                underrun <= 1'b0;
            end
        end
    end

endmodule : direct_sound_fifo

//--- hdl/snd_mixer.sv
`timescale 1ns/1ps

module snd_mixer (
    input  logic                        clk_100,
    input  logic                        rst_n,
    input  logic                        sample_tick,
    input  snd_audio_pkg::chan_sample_t sq_sample,
    input  snd_audio_pkg::chan_sample_t ds_sample,
    input  snd_audio_pkg::route_t       route,
    output snd_audio_pkg::stereo_t      audio_out,
    output logic                        out_valid
);
    import snd_audio_pkg::*;

    localparam logic signed [23:0] SAT_MAX = 24'sd32767;
    localparam logic signed [23:0] SAT_MIN = -24'sd32768;

    mix_sample_t mix_left;
    mix_sample_t mix_right;

    // one side of the mix, 24 bits of headroom before saturation
    function automatic mix_sample_t side_mix(
        input chan_sample_t sq,
        input chan_sample_t ds,
        input logic         sq_on,
        input logic         ds_on,
        input logic [1:0]   sq_shift,
        input logic         ds_full
    );
        logic signed [23:0] sq_term;
        logic signed [23:0] ds_term;
        logic signed [23:0] sum;
        sq_term = '0;
        ds_term = '0;
        if (sq_on) begin
            sq_term = 24'(sq) <<< sq_shift;
        end
        if (ds_on) begin
            ds_term = ds_full ? (24'(ds) <<< 1) : 24'(ds);
        end
        sum = (sq_term + ds_term) <<< 6;
        if (sum > SAT_MAX) begin
            return 16'sh7fff;
        end
        if (sum < SAT_MIN) begin
            return 16'sh8000;
        end
        return mix_sample_t'(sum[15:0]);
    endfunction

    always_comb begin
        mix_left  = side_mix(sq_sample, ds_sample, route.sq_left, route.ds_left,
                             route.sq_shift, route.ds_full);
        mix_right = side_mix(sq_sample, ds_sample, route.sq_right, route.ds_right,
                             route.sq_shift, route.ds_full);
    end

    // output holds between ticks
    always_ff @(posedge clk_100) begin
        if (!rst_n) begin
            audio_out <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= sample_tick;
            if (sample_tick) begin
                audio_out.left  <= mix_left;
                audio_out.right <= mix_right;
            end
        end
    end

endmodule : snd_mixer

//--- hdl/snd_audio_top.sv
`timescale 1ns/1ps

module snd_audio_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk_100,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   sample_tick,
    output snd_audio_pkg::stereo_t audio_out,
    output logic                   out_valid,
    output logic                   fifo_req
);
    import snd_reg_pkg::*;
    import snd_audio_pkg::*;

    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    sq_ctrl_t          sq_cfg;
    logic              sq_restart;
    logic              push;
    fifo_word_u        push_word;
    route_t            route;
    logic              chan_clear;
    logic              underrun_clear;
    logic [LVL_W-1:0]  level;
    logic              full;
    logic              underrun;
    chan_sample_t      sq_sample;
    chan_sample_t      ds_sample;

    snd_apb_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
        .clk_100, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .level, .full, .underrun, .fifo_req,
        .sq_cfg, .sq_restart, .push, .push_word,
        .route, .chan_clear, .underrun_clear
    );

    square_tone u_square (
        .clk_100, .rst_n, .sample_tick,
        .sq_cfg, .sq_restart, .chan_clear,
        .sq_sample
    );

    direct_sound_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_direct (
        .clk_100, .rst_n, .sample_tick,
        .push, .push_word, .chan_clear, .underrun_clear,
        .ds_sample, .level, .full, .underrun, .fifo_req
    );

    snd_mixer u_mixer (
        .clk_100, .rst_n, .sample_tick,
        .sq_sample, .ds_sample, .route,
        .audio_out, .out_valid
    );

endmodule : snd_audio_top

//--- bench/snd_audio_assert.sv
`timescale 1ns/1ps

module snd_audio_assert #(
    parameter int FIFO_DEPTH = 8,
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1)
) (
    input logic             clk_100,
    input logic             rst_n,
    input logic             psel,
    input logic             penable,
    input logic             pready,
    input logic             pslverr,
    input logic             sample_tick,
    input logic             out_valid,
    input logic [LVL_W-1:0] level
);

    a_pready: assert property (@(posedge clk_100) pready)
        else $error("pready went low");

    // output strobe trails the sample tick by one cycle
    a_valid: assert property (@(posedge clk_100) disable iff (!rst_n)
        out_valid == $past(sample_tick))
        else $error("out_valid does not follow sample_tick");

    a_level: assert property (@(posedge clk_100) disable iff (!rst_n)
        level <= LVL_W'(FIFO_DEPTH))
        else $error("FIFO level above depth");

    a_err: assert property (@(posedge clk_100) disable iff (!rst_n)
        !(psel && penable) |-> !pslverr)
        else $error("pslverr outside access phase");

endmodule : snd_audio_assert

bind snd_audio_top snd_audio_assert #(.FIFO_DEPTH(FIFO_DEPTH)) u_assert (
    .clk_100, .rst_n, .psel, .penable, .pready, .pslverr,
    .sample_tick, .out_valid, .level
);

//--- bench/snd_audio_tb.sv
`timescale 1ns/1ps

module snd_audio_tb;
    import snd_reg_pkg::*;
    import snd_audio_pkg::*;

    localparam int DEPTH = 8;
    // limit well above the length of the tests
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk_100 = 1'b0;
    logic rst_n, psel, penable, pwrite, sample_tick;
    logic [7:0] paddr;
    logic [31:0] pwdata, prdata;
    logic pready, pslverr, out_valid, fifo_req;
    stereo_t audio_out;

    // reference model state
    snd_ctrl_t    m_ctrl;
    sq_ctrl_t     m_sq;
    logic [10:0]  m_cnt;
    logic [2:0]   m_step;
    chan_sample_t m_ds;
    logic [31:0]  m_fifo [$];
    logic [1:0]   m_byte;
    logic         m_underrun;

    stereo_t     exp_q [$];
    logic [31:0] lfsr;
    logic        tick_prev = 1'b0;
    int          cycles = 0;
    string       test_name = "reset";

    snd_audio_top #(.FIFO_DEPTH(DEPTH)) uut (
        .clk_100, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .sample_tick, .audio_out, .out_valid, .fifo_req
    );

    always #4 clk_100 = ~clk_100;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_stereo(input string what, input stereo_t exp, input stereo_t act);
        if (exp !== act)
            fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
            fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h",
                               test_name, what, exp, act));
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act)
            fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b",
                               test_name, what, exp, act));
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic mix_sample_t sat16(input int v);
        if (v > 32767) return 16'sh7fff;
        if (v < -32768) return 16'sh8000;
        return 16'(v);
    endfunction

    function automatic stereo_t mix_ref(input chan_sample_t sq, input chan_sample_t ds,
                                        input snd_ctrl_t c);
        int sq_v;
        int ds_v;
        int l;
        int r;
        stereo_t s;
        sq_v = sq * (1 << c.sq_shift);
        ds_v = c.ds_full ? 2 * ds : int'(ds);
        l = (c.sq_left ? sq_v : 0) + (c.ds_left ? ds_v : 0);
        r = (c.sq_right ? sq_v : 0) + (c.ds_right ? ds_v : 0);
        s.left = sat16(l * 64);
        s.right = sat16(r * 64);
        return s;
    endfunction

    function automatic chan_sample_t sq_ref();
        logic high;
        int a;
        if (!m_ctrl.master_en) return '0;
        case (m_sq.duty)
            2'd0:    high = m_step == 3'd7;
            2'd1:    high = m_step >= 3'd6;
            2'd2:    high = m_step >= 3'd4;
            default: high = m_step >= 3'd2;
        endcase
        a = int'(m_sq.volume) * 8;
        return chan_sample_t'(high ? a : -a);
    endfunction

    function automatic logic [31:0] status_ref();
        logic req;
        logic [7:0] lvl;
        req = m_fifo.size() <= DEPTH / 2;
        lvl = 8'(m_fifo.size());
        return {22'd0, req, m_underrun, lvl};
    endfunction

    function automatic void advance_model();
        if (m_ctrl.master_en) begin
            if (m_cnt == m_sq.period) begin
                m_cnt = '0;
                m_step = m_step + 3'd1;
            end else begin
                m_cnt = m_cnt + 11'd1;
            end
            if (m_fifo.size() == 0) begin
                m_ds = '0;
                m_underrun = 1'b1;
            end else begin
                // lowest byte plays first
                m_ds = chan_sample_t'(m_fifo[0] >> (8 * m_byte));
                if (m_byte == 2'd3) m_fifo.delete(0);
                m_byte = m_byte + 2'd1;
            end
        end
    endfunction

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic err, output logic [31:0] rdata);
        @(posedge clk_100);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk_100);
        penable <= 1'b1;
        @(negedge clk_100);
        err = pslverr;
        rdata = prdata;
        check_bit("pready", 1'b1, pready);
        @(posedge clk_100);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic exp_err;
        logic err;
        logic [31:0] rd;
        exp_err = !(addr inside {ADDR_SND_CTRL, ADDR_SQ_CTRL, ADDR_FIFO, ADDR_STATUS})
                  || (addr == ADDR_FIFO && m_fifo.size() == DEPTH);
        apb_xfer(1'b1, addr, data, err, rd);
        check_bit("pslverr on write", exp_err, err);
        if (!exp_err) begin
            case (addr)
                ADDR_SND_CTRL: m_ctrl = snd_ctrl_t'(data[7:0]);
                ADDR_SQ_CTRL: begin
                    m_sq = sq_ctrl_t'(data[16:0]);
                    m_cnt = '0;
                    m_step = '0;
                end
                ADDR_FIFO: if (m_ctrl.master_en) m_fifo.push_back(data);
                default: if (data[8]) m_underrun = 1'b0;
            endcase
        end
        // master off keeps both channels cleared
        if (!m_ctrl.master_en) begin
            m_fifo.delete();
            m_byte = '0;
            m_ds = '0;
            m_cnt = '0;
            m_step = '0;
        end
    endtask

    task automatic read_reg(input logic [7:0] addr);
        logic exp_err;
        logic [31:0] exp_rd;
        logic err;
        logic [31:0] rd;
        exp_err = 1'b0;
        exp_rd = '0;
        case (addr)
            ADDR_SND_CTRL: exp_rd = {24'd0, m_ctrl};
            ADDR_SQ_CTRL:  exp_rd = {15'd0, m_sq};
            ADDR_STATUS:   exp_rd = status_ref();
            default:       exp_err = 1'b1;
        endcase
        apb_xfer(1'b0, addr, 32'd0, err, rd);
        check_bit("pslverr on read", exp_err, err);
        check_word("prdata", exp_rd, rd);
    endtask

    task automatic tick();
        @(posedge clk_100);
        sample_tick <= 1'b1;
        exp_q.push_back(mix_ref(sq_ref(), m_ds, m_ctrl));
        advance_model();
        @(posedge clk_100);
        sample_tick <= 1'b0;
    endtask

    task automatic check_req();
        @(negedge clk_100);
        check_bit("fifo_req", m_fifo.size() <= DEPTH / 2, fifo_req);
    endtask

    // compare every output sample against the queued reference
    always @(negedge clk_100) begin
        logic prev;
        prev = tick_prev;
        tick_prev = sample_tick;
        if (rst_n && out_valid !== prev) begin
            fail_run("out_valid did not come one cycle after a sample tick");
        end else if (rst_n && out_valid) begin
            if (exp_q.size() == 0)
                fail_run("an output sample arrived with no expected value");
            else
                check_stereo("audio_out", exp_q.pop_front(), audio_out);
        end
    end

    always @(posedge clk_100) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
            fail_run("run exceeded its cycle limit, DUT or bench is stuck");
    end

    initial begin
        logic [31:0] r;
        logic [7:0] ctrl_b;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        sample_tick = 1'b0;
        lfsr = 32'h40f7;
        m_ctrl = '0;
        m_sq = '0;
        m_cnt = '0;
        m_step = '0;
        m_ds = '0;
        m_byte = '0;
        m_underrun = 1'b0;
        repeat (8) @(posedge clk_100);
        rst_n <= 1'b1;

        @(negedge clk_100);
        check_bit("out_valid", 1'b0, out_valid);
        check_stereo("audio_out", '0, audio_out);
        check_bit("fifo_req", 1'b1, fifo_req);
        read_reg(ADDR_STATUS);

        test_name = "registers";
        write_reg(ADDR_SND_CTRL, 32'h0000_00a5);
        read_reg(ADDR_SND_CTRL);
        write_reg(ADDR_SQ_CTRL, 32'hffff_a5c3);
        read_reg(ADDR_SQ_CTRL);
        read_reg(8'h10);
        read_reg(ADDR_FIFO);
        write_reg(8'h14, 32'h1);
        write_reg(ADDR_SND_CTRL, 32'h80);
        for (int i = 0; i <= DEPTH; i++) write_reg(ADDR_FIFO, 32'h1111_1111 * i);
        read_reg(ADDR_STATUS);
        check_req();
        write_reg(ADDR_SND_CTRL, 32'h00);
        read_reg(ADDR_STATUS);

        test_name = "square";
        write_reg(ADDR_SND_CTRL, 32'hc0);
        for (int d = 0; d < 4; d++) begin
            write_reg(ADDR_SQ_CTRL, {15'd0, 2'(d), 4'(3 + 4 * d), 11'(d)});
            repeat ((d + 1) * 8 + 2) tick();
        end
        // rewrite mid period restarts at step 0
        repeat (5) tick();
        write_reg(ADDR_SQ_CTRL, {15'd0, 2'd3, 4'd9, 11'd1});
        repeat (6) tick();

        test_name = "direct";
        write_reg(ADDR_SND_CTRL, 32'h98);
        for (int i = 0; i < 6; i++) begin
            write_reg(ADDR_FIFO, 32'h0302_0100 + 32'h2424_2424 * i);
            check_req();
        end
        repeat (6 * 4 + 3) tick();
        read_reg(ADDR_STATUS);
        write_reg(ADDR_STATUS, 32'h100);
        read_reg(ADDR_STATUS);
        write_reg(ADDR_FIFO, 32'h5a5a_a5a5);
        write_reg(ADDR_FIFO, 32'h7f80_017f);
        tick();
        write_reg(ADDR_SND_CTRL, 32'h18);
        read_reg(ADDR_STATUS);
        check_req();
        write_reg(ADDR_SND_CTRL, 32'h98);
        repeat (2) tick();

        test_name = "mix";
        write_reg(ADDR_SQ_CTRL, {15'd0, 2'd2, 4'd15, 11'd0});
        for (int sh = 0; sh < 4; sh++) begin
            for (int f = 0; f < 2; f++) begin
                write_reg(ADDR_SND_CTRL, {24'd0, 5'b11011, 1'(f), 2'(sh)});
                write_reg(ADDR_FIFO, 32'h10f0_807f);
                repeat (5) tick();
            end
        end

        test_name = "random";
        for (int n = 0; n < 600; n++) begin
            r = rand_bits(3);
            case (r[2:0])
                3'd4, 3'd5: write_reg(ADDR_FIFO, rand_bits(32));
                3'd6: begin
                    r = rand_bits(10);
                    ctrl_b = r[7:0];
                    if (r[9:8] != 2'd0) ctrl_b[7] = 1'b1;
                    write_reg(ADDR_SND_CTRL, {24'd0, ctrl_b});
                end
                3'd7: begin
                    r = rand_bits(11);
                    case (r[10:9])
                        2'd0: write_reg(ADDR_SQ_CTRL, {15'd0, r[8:7], r[6:3], 8'd0, r[2:0]});
                        2'd1: write_reg(ADDR_STATUS, {23'd0, r[0], 8'd0});
                        2'd2: read_reg(ADDR_STATUS);
                        default: read_reg({4'd0, r[1:0], 2'd0});
                    endcase
                end
                default: tick();
            endcase
        end
        check_req();

        while (exp_q.size() != 0) @(posedge clk_100);
        @(negedge clk_100);
        $display("All tests passed!");
        $finish;
    end

endmodule : snd_audio_tb

//--- files.f
hdl/snd_reg_pkg.sv
hdl/snd_audio_pkg.sv
hdl/snd_apb_regs.sv
hdl/square_tone.sv
hdl/direct_sound_fifo.sv
hdl/snd_mixer.sv
hdl/snd_audio_top.sv
bench/snd_audio_assert.sv
bench/snd_audio_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := snd_audio_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
